//--- Bender.yml
package:
  name: sdram_fifo

sources:
  - include_dirs:
      - design
    files:
      - design/sdram_fifo_pkg.sv
      - design/sample_packer.sv
      - design/sync_fifo.sv
      - design/bulk_store.sv
      - design/transfer_engine.sv
      - design/occupancy_monitor.sv
      - design/sdram_fifo_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/fifo_checker.sv
      - tb/tb_sdram_fifo.sv

//--- compile.f
+incdir+design
design/sdram_fifo_pkg.sv
design/sample_packer.sv
design/sync_fifo.sv
design/bulk_store.sv
design/transfer_engine.sv
design/occupancy_monitor.sv
design/sdram_fifo_top.sv
tb/fifo_checker.sv
tb/tb_sdram_fifo.sv

//--- design/bulk_store.sv
`timescale 1ns/100ps
`include "sdram_fifo_params.svh"

// Circular chunk memory standing in for the external SDRAM
module bulk_store (
	input logic ti_clk,
	input logic reset,
	input sdram_fifo_pkg::store_wr_t wr,
	input logic rd_en,
	output sdram_fifo_pkg::chunk_t rd_data,
	output logic has_data
);

	localparam int n_chunks = 2 ** `SF_STORE_AW;

	sdram_fifo_pkg::chunk_t mem [n_chunks];
	sdram_fifo_pkg::store_addr_t wr_ptr;
	sdram_fifo_pkg::store_addr_t rd_ptr;

	assign has_data = (wr_ptr != rd_ptr);
	assign rd_data = mem[rd_ptr];

	////////////////////////////////////////
	// Pointers
	////////////////////////////////////////

	// Writes never stall, so a full store laps the reader
	always_ff @(posedge ti_clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr.en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge ti_clk) begin
		if (wr.en)
			mem[wr_ptr] <= wr.data;
	end

	// The transfer engine only unloads what it saw present
	a_rd_has_data: assert property (@(posedge ti_clk) disable iff (reset) rd_en |-> has_data)
		else $error("bulk_store: read without data");

endmodule

//--- design/occupancy_monitor.sv
`timescale 1ns/100ps
`include "sdram_fifo_params.svh"

// Word count over the whole FIFO and the block ready flag
module occupancy_monitor (
	input logic ti_clk,
	input logic reset,
	input logic write_to,
	input logic read_from,
	input logic out_empty,
	input sdram_fifo_pkg::out_cnt_t out_count,
	input sdram_fifo_pkg::out_cnt_t block_size,
	output sdram_fifo_pkg::level_t num_words,
	output logic out_rdy
);

	localparam int words_per_read = `SF_OUT_W / `SF_SAMPLE_W;

	logic rd_eff;
	sdram_fifo_pkg::level_t add_words;
	sdram_fifo_pkg::level_t sub_words;

	// Reads of an empty output FIFO remove nothing
	assign rd_eff = read_from && !out_empty;
	assign add_words = write_to ? sdram_fifo_pkg::level_t'(1) : '0;
	assign sub_words = rd_eff ? sdram_fifo_pkg::level_t'(words_per_read) : '0;

	always_ff @(posedge ti_clk) begin
		if (reset) begin
			num_words <= '0;
			out_rdy <= 1'b0;
		end else begin
			num_words <= num_words + add_words - sub_words;
			out_rdy <= (out_count >= block_size);
		end
	end

endmodule

//--- design/sample_packer.sv
`timescale 1ns/100ps
`include "sdram_fifo_params.svh"

// Collects sample words into 64-bit chunks
module sample_packer (
	input logic ti_clk,
	input logic reset,
	input logic write_to,
	input sdram_fifo_pkg::sample_t data_in,
	output logic push,
	output sdram_fifo_pkg::chunk_t chunk
);

	logic [1:0] word_idx;
	logic [2:0][`SF_SAMPLE_W-1:0] hold;

	////////////////////////////////////////
	// Word index and chunk strobe
	////////////////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (reset) begin
			word_idx <= 2'd0;
			push <= 1'b0;
		end else begin
			push <= write_to && (word_idx == 2'd3);
			if (write_to)
				word_idx <= word_idx + 2'd1;
		end
	end

	// Words 0..2 wait here, a partial chunk may wait forever
	always_ff @(posedge ti_clk) begin
		if (write_to) begin
			if (word_idx == 2'd3)
				chunk <= {data_in, hold[2], hold[1], hold[0]};
			else
				hold[word_idx] <= data_in;
		end
	end

endmodule

//--- design/sdram_fifo_params.svh
`ifndef SDRAM_FIFO_PARAMS_SVH
`define SDRAM_FIFO_PARAMS_SVH

// Data path widths
`define SF_SAMPLE_W 16
`define SF_CHUNK_W 64
`define SF_OUT_W 32

// Bulk store holds 2**SF_STORE_AW chunks
`define SF_STORE_AW 8

// Small FIFOs on either side of the store
`define SF_IN_DEPTH 8
`define SF_OUT_DEPTH 32

// Status widths
`define SF_LEVEL_W 32
`define SF_OUT_CNT_W 6

`endif

//--- design/sdram_fifo_pkg.sv
`include "sdram_fifo_params.svh"

package sdram_fifo_pkg;

	// One sample word from the acquisition side
	typedef logic [`SF_SAMPLE_W-1:0] sample_t;

	// Four samples, word 0 in bits 15:0
	typedef logic [`SF_CHUNK_W-1:0] chunk_t;

	// Word as seen by the host
	typedef logic [`SF_OUT_W-1:0] out_word_t;

	typedef logic [`SF_LEVEL_W-1:0] level_t;
	typedef logic [`SF_OUT_CNT_W-1:0] out_cnt_t;
	typedef logic [`SF_STORE_AW-1:0] store_addr_t;

	// Write port of the bulk store
	typedef struct packed {
		logic en;
		chunk_t data;
	} store_wr_t;

endpackage

//--- design/sdram_fifo_top.sv
`timescale 1ns/100ps
`include "sdram_fifo_params.svh"

// Streaming FIFO: packer, chunk FIFO, bulk store, output FIFO
module sdram_fifo_top (
	input logic ti_clk,
	input logic reset,
	input logic write_to,
	input sdram_fifo_pkg::sample_t data_in,
	input logic read_from,
	input sdram_fifo_pkg::out_cnt_t block_size,
	output sdram_fifo_pkg::out_word_t data_out,
	output logic out_rdy,
	output sdram_fifo_pkg::level_t num_words
);

	logic pack_push;
	sdram_fifo_pkg::chunk_t pack_chunk;
	sdram_fifo_pkg::chunk_t in_head;
	logic in_empty;
	logic in_pop;
	sdram_fifo_pkg::store_wr_t store_wr;
	logic store_rd_en;
	sdram_fifo_pkg::chunk_t store_chunk;
	logic store_has_data;
	logic out_push;
	sdram_fifo_pkg::out_word_t out_word;
	logic out_empty;
	sdram_fifo_pkg::out_cnt_t out_count;

	////////////////////////////////////////
	// Write side
	////////////////////////////////////////

	sample_packer u_packer (
		.ti_clk(ti_clk), .reset(reset), .write_to(write_to), .data_in(data_in),
		.push(pack_push), .chunk(pack_chunk)
	);

	sync_fifo #(.payload_t(sdram_fifo_pkg::chunk_t), .depth(`SF_IN_DEPTH)) u_in_fifo (
		.ti_clk(ti_clk), .reset(reset), .push(pack_push), .wdata(pack_chunk),
		.pop(in_pop), .rdata(in_head), .empty(in_empty), .count()
	);

	////////////////////////////////////////
	// Store and transfer
	////////////////////////////////////////

	transfer_engine u_engine (
		.ti_clk(ti_clk), .reset(reset), .in_empty(in_empty), .in_chunk(in_head),
		.store_has_data(store_has_data), .store_chunk(store_chunk),
		.out_count(out_count), .in_pop(in_pop), .store_wr(store_wr),
		.store_rd_en(store_rd_en), .out_push(out_push), .out_word(out_word)
	);

	bulk_store u_store (
		.ti_clk(ti_clk), .reset(reset), .wr(store_wr), .rd_en(store_rd_en),
		.rd_data(store_chunk), .has_data(store_has_data)
	);

	// Host side
	sync_fifo #(.payload_t(sdram_fifo_pkg::out_word_t), .depth(`SF_OUT_DEPTH)) u_out_fifo (
		.ti_clk(ti_clk), .reset(reset), .push(out_push), .wdata(out_word),
		.pop(read_from), .rdata(data_out), .empty(out_empty), .count(out_count)
	);

	occupancy_monitor u_monitor (
		.ti_clk(ti_clk), .reset(reset), .write_to(write_to), .read_from(read_from),
		.out_empty(out_empty), .out_count(out_count), .block_size(block_size),
		.num_words(num_words), .out_rdy(out_rdy)
	);

endmodule

//--- design/sync_fifo.sv
`timescale 1ns/100ps
`include "sdram_fifo_params.svh"

// Single-clock FIFO with the head word visible without a read strobe
module sync_fifo #(
	parameter type payload_t = sdram_fifo_pkg::chunk_t,
	parameter int depth = `SF_IN_DEPTH
) (
	input logic ti_clk,
	input logic reset,
	input logic push,
	input payload_t wdata,
	input logic pop,
	output payload_t rdata,
	output logic empty,
	output logic [$clog2(depth+1)-1:0] count
);

	localparam int aw = $clog2(depth);
	localparam int cw = $clog2(depth + 1);

	payload_t mem [depth];
	payload_t last;
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic full;
	logic do_push;
	logic do_pop;

	function automatic logic [aw-1:0] bump(input logic [aw-1:0] ptr);
		return (ptr == aw'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign full = (count == cw'(depth));
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// Once drained, the last popped word stays on the output
	assign rdata = empty ? last : mem[rd_ptr];

	always_ff @(posedge ti_clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= bump(wr_ptr);
			if (do_pop)
				rd_ptr <= bump(rd_ptr);
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge ti_clk) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
		if (do_pop)
			last <= mem[rd_ptr];
	end

	////////////////////////////////////////
	// Protocol checks
	////////////////////////////////////////

	// Upstream must hold off while no slot is free
	a_push_full: assert property (@(posedge ti_clk) disable iff (reset) push |-> !full)
		else $error("sync_fifo: push while full");

endmodule

//--- design/transfer_engine.sv
`timescale 1ns/100ps
`include "sdram_fifo_params.svh"

// Moves chunks into the bulk store and unloads them as host words
module transfer_engine (
	input logic ti_clk,
	input logic reset,
	input logic in_empty,
	input sdram_fifo_pkg::chunk_t in_chunk,
	input logic store_has_data,
	input sdram_fifo_pkg::chunk_t store_chunk,
	input sdram_fifo_pkg::out_cnt_t out_count,
	output logic in_pop,
	output sdram_fifo_pkg::store_wr_t store_wr,
	output logic store_rd_en,
	output logic out_push,
	output sdram_fifo_pkg::out_word_t out_word
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SEND_LO,
		ST_SEND_HI
	} state_t;

	state_t state;
	logic room;

	// Both halves of a chunk must fit in the output FIFO
	assign room = (out_count <= sdram_fifo_pkg::out_cnt_t'(`SF_OUT_DEPTH - 2));

	////////////////////////////////////////
	// State machine
	////////////////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					// Writes into the store take priority
					if (in_empty && store_has_data && room)
						state <= ST_SEND_LO;
				end
				ST_SEND_LO: state <= ST_SEND_HI;
				ST_SEND_HI: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Store write straight from the chunk FIFO head
	assign in_pop = (state == ST_IDLE) && !in_empty;
	assign store_wr.en = in_pop;
	assign store_wr.data = in_chunk;

	// Low half first, the store advances with the high half
	assign out_push = (state == ST_SEND_LO) || (state == ST_SEND_HI);
	assign store_rd_en = (state == ST_SEND_HI);

	always_comb begin
		if (state == ST_SEND_HI)
			out_word = store_chunk[`SF_CHUNK_W-1:`SF_OUT_W];
		else
			out_word = store_chunk[`SF_OUT_W-1:0];
	end

endmodule

//--- tb/fifo_checker.sv
`timescale 1ns/100ps

// Watches the DUT ports and compares them with a word-queue model
module fifo_checker (
	input logic ti_clk,
	input logic reset,
	input logic write_to,
	input sdram_fifo_pkg::sample_t data_in,
	input logic read_from,
	input sdram_fifo_pkg::out_cnt_t block_size,
	input sdram_fifo_pkg::out_word_t data_out,
	input logic out_rdy,
	input sdram_fifo_pkg::level_t num_words,
	output int errors
);

	// Cycles without traffic before the ready flag has to match
	localparam int quiet_cycles = 12;

	sdram_fifo_pkg::sample_t words [$];
	sdram_fifo_pkg::level_t model_count;
	sdram_fifo_pkg::out_word_t expect_word;
	sdram_fifo_pkg::out_word_t last_out;
	sdram_fifo_pkg::out_cnt_t last_block;
	int written;
	int entries_read;
	int out_entries;
	int quiet;
	logic rdy_exp;

	initial errors = 0;

	always @(posedge ti_clk) begin
		if (reset) begin
			words.delete();
			model_count = '0;
			written = 0;
			entries_read = 0;
			quiet = 0;
		end else begin
			// num_words lags by one edge
			if (num_words !== model_count) begin
				$display("[FAIL] num_words expected %h got %h", model_count, num_words);
				errors++;
			end
			// Every complete chunk gives two host words
			out_entries = 2 * (written / 4) - entries_read;
			rdy_exp = (out_entries >= block_size);
			if (quiet >= quiet_cycles && out_rdy !== rdy_exp) begin
				$display("[FAIL] out_rdy expected %h got %h", rdy_exp, out_rdy);
				errors++;
			end
			if (read_from && out_entries > 0) begin
				expect_word[15:0] = words.pop_front();
				expect_word[31:16] = words.pop_front();
				if (data_out !== expect_word) begin
					$display("[FAIL] data_out expected %h got %h", expect_word, data_out);
					errors++;
				end
				last_out = expect_word;
				entries_read++;
				model_count = model_count - 2;
			end else if (read_from && entries_read > 0 && data_out !== last_out) begin
				// Empty read, the last word stays on the bus
				$display("[FAIL] data_out expected %h got %h", last_out, data_out);
				errors++;
			end
			if (write_to) begin
				words.push_back(data_in);
				written++;
				model_count = model_count + 1;
			end
			quiet = (write_to || read_from || block_size != last_block) ? 0 : quiet + 1;
		end
		last_block = block_size;
	end

endmodule

//--- tb/tb_sdram_fifo.sv
`timescale 1ns/100ps
`include "sdram_fifo_params.svh"

module tb_sdram_fifo;

	localparam int settle_cycles = 16;
	localparam int chunk_settle = 12;
	localparam int ready_limit = 300;

	logic ti_clk;
	logic reset;
	logic write_to;
	sdram_fifo_pkg::sample_t data_in;
	logic read_from;
	sdram_fifo_pkg::out_cnt_t block_size;
	sdram_fifo_pkg::out_word_t data_out;
	logic out_rdy;
	sdram_fifo_pkg::level_t num_words;
	int chk_errors;
	int timeouts;
	int tests_run;
	int tests_failed;
	int mark;
	int host_written;
	int host_read;
	int since_chunk;
	int since_act;
	int bs;
	int i;
	logic [31:0] lfsr;
	logic w;
	logic r;

	sdram_fifo_top uut (
		.ti_clk(ti_clk), .reset(reset), .write_to(write_to), .data_in(data_in),
		.read_from(read_from), .block_size(block_size), .data_out(data_out),
		.out_rdy(out_rdy), .num_words(num_words)
	);

	fifo_checker chk (
		.ti_clk(ti_clk), .reset(reset), .write_to(write_to), .data_in(data_in),
		.read_from(read_from), .block_size(block_size), .data_out(data_out),
		.out_rdy(out_rdy), .num_words(num_words), .errors(chk_errors)
	);

	initial begin
		ti_clk = 1'b0;
		forever #20 ti_clk = ~ti_clk;
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int k;
		v = '0;
		for (k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
		end
		return v;
	endfunction

	// Host may read once a complete chunk has had time to reach the output FIFO
	function automatic logic can_read();
		return (host_read < 2 * (host_written / 4)) && (since_chunk >= chunk_settle);
	endfunction

	////////////////////////////////////////
	// Host side drivers
	////////////////////////////////////////

	task automatic step(input logic wr, input logic rd);
		@(negedge ti_clk);
		write_to = wr;
		read_from = rd;
		data_in = wr ? sdram_fifo_pkg::sample_t'(rand_bits(16)) : '0;
		since_chunk++;
		since_act = (wr || rd) ? 0 : since_act + 1;
		if (rd && host_read < 2 * (host_written / 4))
			host_read++;
		if (wr) begin
			host_written++;
			if (host_written % 4 == 0)
				since_chunk = 0;
		end
	endtask

	task automatic settle();
		while (since_act < settle_cycles)
			step(1'b0, 1'b0);
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (out_rdy !== 1'b1 && n < ready_limit) begin
			step(1'b0, 1'b0);
			n++;
		end
		if (out_rdy !== 1'b1) begin
			$display("Timeout: out_rdy stayed low for %0d cycles", ready_limit);
			timeouts++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (chk_errors + timeouts == mark) begin
			$display("Test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: failed", tests_run, name);
		end
		mark = chk_errors + timeouts;
	endtask

	initial begin
		reset = 1'b1;
		write_to = 1'b0;
		read_from = 1'b0;
		data_in = '0;
		block_size = 6'd1;
		lfsr = 32'hba53;
		{timeouts, tests_run, tests_failed, mark} = '0;
		{host_written, host_read, since_chunk, since_act} = '0;
		repeat (2) @(posedge ti_clk);
		@(negedge ti_clk);
		reset = 1'b0;
		settle();
		end_test("after reset");

		// Fill the output FIFO completely, then drain it
		block_size = 6'(`SF_OUT_DEPTH);
		i = 0;
		while (i < 2 * `SF_OUT_DEPTH) begin
			w = (rand_bits(1) != 32'd0);
			step(w, 1'b0);
			if (w)
				i++;
		end
		wait_ready();
		settle();
		repeat (`SF_OUT_DEPTH) step(1'b0, 1'b1);
		settle();
		end_test("data order and count");

		bs = 1 + rand_bits(4);
		block_size = 6'(bs);
		repeat (4 * bs) step(1'b1, 1'b0);
		wait_ready();
		settle();
		repeat (bs + 1) step(1'b0, 1'b1);
		settle();
		repeat (bs - 1) step(1'b0, 1'b1);
		settle();
		end_test("ready flag");

		////////////////////////////////////////
		// Partial chunk and empty read
		////////////////////////////////////////
		block_size = 6'd2;
		repeat (6) step(1'b1, 1'b0);
		wait_ready();
		settle();
		repeat (3) step(1'b0, 1'b1);
		settle();
		repeat (2) step(1'b1, 1'b0);
		wait_ready();
		settle();
		repeat (2) step(1'b0, 1'b1);
		settle();
		end_test("partial chunk");

		for (i = 0; i < 500; i++) begin
			w = (rand_bits(2) == 32'd3) && (host_written - 2 * host_read < 56);
			r = rand_bits(1) && can_read();
			step(w, r);
		end
		settle();
		end_test("interleaved traffic");

		$display("Tests run %0d, failed %0d, check errors %0d, timeouts %0d",
			tests_run, tests_failed, chk_errors, timeouts);
		if (chk_errors + timeouts == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
